// File: flist.f
logic/coh_pkg.sv
logic/dmem_pkg.sv
logic/coh_decode.sv
logic/mshr_issue.sv
logic/mshr_response.sv
logic/dmem_ctrl.sv
sim/tb_dmem_ctrl.sv

// File: logic/coh_decode.sv
// Coherence request decoder
// Holds the directory state (I, S or M) of every line and applies
// the MSI decision table to the line addressed by the current bus
// request. Acks are decided in the same cycle; the state table and
// any new issue queue entry are written at the next rising edge.

`timescale 1ns/1ps

module coh_decode (
	input  logic                           clk,
	input  logic                           rst,

	// bus request
	input  coh_pkg::coh_msg_e              bus_req_msg_i,
	input  logic [dmem_pkg::LINE_ADDR_W-1:0] bus_req_addr_i,

	// issue queue status
	input  logic                           iss_full_i,
	input  logic                           dmem_accept_i,

	output logic                           bus_req_ack_o,
	output logic                           alloc_o,
	output dmem_pkg::dmem_cmd_e            alloc_cmd_o
);

	import coh_pkg::*;
	import dmem_pkg::*;

	// directory state per line
	line_state_e state_r [NUM_LINES];

	line_state_e cur_state;
	line_state_e nxt_state;
	logic        stall;

	assign cur_state = state_r[bus_req_addr_i];

	// a full queue still takes an entry if the head leaves this cycle
	assign stall = iss_full_i && !dmem_accept_i;

	// --------------------
	// decision table
	// --------------------

	always_comb begin
		bus_req_ack_o = 1'b0;
		alloc_o       = 1'b0;
		alloc_cmd_o   = CMD_NONE;
		nxt_state     = cur_state;
		case (cur_state)
			ST_I: begin
				if (bus_req_msg_i == GET_S) begin
					// memory supplies the data
					bus_req_ack_o = !stall;
					alloc_o       = !stall;
					alloc_cmd_o   = CMD_LOAD;
					nxt_state     = ST_S;
				end else if (bus_req_msg_i == GET_M) begin
					bus_req_ack_o = 1'b1;
					nxt_state     = ST_M;
				end
			end
			ST_S: begin
				if (bus_req_msg_i == GET_M) begin
					bus_req_ack_o = 1'b1;
					nxt_state     = ST_M;
				end
			end
			ST_M: begin
				// owner writes the line back, entry waits for its data
				if (bus_req_msg_i == PUT_M) begin
					bus_req_ack_o = !stall;
					alloc_o       = !stall;
					alloc_cmd_o   = CMD_STORE;
					nxt_state     = ST_I;
				end else if (bus_req_msg_i == GET_S) begin
					bus_req_ack_o = !stall;
					alloc_o       = !stall;
					alloc_cmd_o   = CMD_STORE;
					nxt_state     = ST_S;
				end
			end
			default: begin
				nxt_state = cur_state;
			end
		endcase
	end

	// --------------------
	// state table
	// --------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				state_r[i] <= ST_I;
			end
		end else if (bus_req_ack_o) begin
			state_r[bus_req_addr_i] <= nxt_state;
		end
	end

endmodule

// File: logic/coh_pkg.sv
// Coherence definitions package
// Bus request messages and directory line states for the
// memory-side MSI controller. The decoder, the top level and
// the testbench share these encodings.

package coh_pkg;

	// --------------------
	// bus request messages
	// --------------------

	// MSG_NONE marks an idle request slot
	typedef enum logic [1:0] {
		MSG_NONE = 2'd0,
		GET_S    = 2'd1,
		GET_M    = 2'd2,
		PUT_M    = 2'd3
	} coh_msg_e;

	// --------------------
	// directory line states
	// --------------------

	// memory owns the line in I, shares it in S, a cache owns it in M
	typedef enum logic [1:0] {
		ST_I = 2'd0,
		ST_S = 2'd1,
		ST_M = 2'd2
	} line_state_e;

endpackage

// File: logic/dmem_ctrl.sv
// Memory-side coherence controller
// Tracks MSI directory state for every line, acks bus requests,
// queues loads and write-backs towards a tagged data memory and
// returns load data to the bus with its response queue pointer.

`timescale 1ns/1ps

module dmem_ctrl #(
	parameter int MSHR_NUM = 4
) (
	input  logic                             clk,
	input  logic                             rst,

	// bus requests
	input  coh_pkg::coh_msg_e                bus_req_msg_i,
	input  logic [dmem_pkg::LINE_ADDR_W-1:0] bus_req_addr_i,
	input  logic [dmem_pkg::PTR_W-1:0]       bus_req_ptr_i,
	output logic                             bus_req_ack_o,

	// bus write-back
	input  logic                             bus_wb_vld_i,
	input  logic [dmem_pkg::LINE_ADDR_W-1:0] bus_wb_addr_i,
	input  logic [dmem_pkg::WORD_W-1:0]      bus_wb_data_i,

	// bus data response
	output logic                             bus_rsp_vld_o,
	output logic [dmem_pkg::PTR_W-1:0]       bus_rsp_ptr_o,
	output logic [dmem_pkg::WORD_W-1:0]      bus_rsp_data_o,

	// data memory
	output dmem_pkg::dmem_cmd_e              dmem_cmd_o,
	output logic [dmem_pkg::LINE_ADDR_W-1:0] dmem_addr_o,
	output logic [dmem_pkg::WORD_W-1:0]      dmem_data_o,
	input  logic [dmem_pkg::TAG_W-1:0]       dmem_resp_tag_i,
	input  logic [dmem_pkg::TAG_W-1:0]       dmem_ret_tag_i,
	input  logic [dmem_pkg::WORD_W-1:0]      dmem_data_i
);

	import dmem_pkg::*;

	logic             iss_full;
	logic             dmem_accept;
	logic             alloc;
	dmem_cmd_e        alloc_cmd;
	logic             rsp_stall;
	logic             push;
	logic [TAG_W-1:0] push_tag;
	logic [PTR_W-1:0] push_ptr;

	coh_decode coh_decode_i (
		.clk            (clk),
		.rst            (rst),
		.bus_req_msg_i  (bus_req_msg_i),
		.bus_req_addr_i (bus_req_addr_i),
		.iss_full_i     (iss_full),
		.dmem_accept_i  (dmem_accept),
		.bus_req_ack_o  (bus_req_ack_o),
		.alloc_o        (alloc),
		.alloc_cmd_o    (alloc_cmd)
	);

	// request address and pointer go straight into the new entry
	mshr_issue #(
		.MSHR_NUM (MSHR_NUM)
	) mshr_issue_i (
		.clk             (clk),
		.rst             (rst),
		.alloc_i         (alloc),
		.alloc_cmd_i     (alloc_cmd),
		.alloc_addr_i    (bus_req_addr_i),
		.alloc_ptr_i     (bus_req_ptr_i),
		.bus_wb_vld_i    (bus_wb_vld_i),
		.bus_wb_addr_i   (bus_wb_addr_i),
		.bus_wb_data_i   (bus_wb_data_i),
		.rsp_stall_i     (rsp_stall),
		.dmem_resp_tag_i (dmem_resp_tag_i),
		.full_o          (iss_full),
		.dmem_accept_o   (dmem_accept),
		.dmem_cmd_o      (dmem_cmd_o),
		.dmem_addr_o     (dmem_addr_o),
		.dmem_data_o     (dmem_data_o),
		.push_o          (push),
		.push_tag_o      (push_tag),
		.push_ptr_o      (push_ptr)
	);

	mshr_response #(
		.MSHR_NUM (MSHR_NUM)
	) mshr_response_i (
		.clk            (clk),
		.rst            (rst),
		.push_i         (push),
		.push_tag_i     (push_tag),
		.push_ptr_i     (push_ptr),
		.dmem_ret_tag_i (dmem_ret_tag_i),
		.dmem_data_i    (dmem_data_i),
		.rsp_stall_o    (rsp_stall),
		.bus_rsp_vld_o  (bus_rsp_vld_o),
		.bus_rsp_ptr_o  (bus_rsp_ptr_o),
		.bus_rsp_data_o (bus_rsp_data_o)
	);

endmodule

// File: logic/dmem_pkg.sv
// Data memory side package
// Widths of line addresses, data words, bus queue pointers and
// memory tags, plus the command encoding sent to the tagged
// variable-latency data memory.

package dmem_pkg;

	// --------------------
	// widths
	// --------------------

	// one 64-bit word per line
	localparam int LINE_ADDR_W = 6;
	localparam int NUM_LINES   = 1 << LINE_ADDR_W;
	localparam int WORD_W      = 64;

	// bus response queue pointer
	localparam int PTR_W       = 3;

	// memory transaction tag, zero means no transaction
	localparam int TAG_W       = 4;
	localparam logic [TAG_W-1:0] TAG_NONE = '0;

	// --------------------
	// memory commands
	// --------------------

	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_LOAD  = 2'd1,
		CMD_STORE = 2'd2
	} dmem_cmd_e;

endpackage

// File: logic/mshr_issue.sv
// Memory issue queue
// Circular queue of load and store entries waiting to be sent to
// the data memory. Loads enter ready; stores wait until the owning
// cache writes the line back. The head entry drives the memory
// command, leaves when memory returns a nonzero tag, and accepted
// loads are handed to the response queue with their bus pointer.

`timescale 1ns/1ps

module mshr_issue #(
	parameter int MSHR_NUM = 4
) (
	input  logic                             clk,
	input  logic                             rst,

	// allocation from the decoder
	input  logic                             alloc_i,
	input  dmem_pkg::dmem_cmd_e              alloc_cmd_i,
	input  logic [dmem_pkg::LINE_ADDR_W-1:0] alloc_addr_i,
	input  logic [dmem_pkg::PTR_W-1:0]       alloc_ptr_i,

	// write-back data from the bus
	input  logic                             bus_wb_vld_i,
	input  logic [dmem_pkg::LINE_ADDR_W-1:0] bus_wb_addr_i,
	input  logic [dmem_pkg::WORD_W-1:0]      bus_wb_data_i,

	input  logic                             rsp_stall_i,
	input  logic [dmem_pkg::TAG_W-1:0]       dmem_resp_tag_i,

	output logic                             full_o,
	output logic                             dmem_accept_o,
	output dmem_pkg::dmem_cmd_e              dmem_cmd_o,
	output logic [dmem_pkg::LINE_ADDR_W-1:0] dmem_addr_o,
	output logic [dmem_pkg::WORD_W-1:0]      dmem_data_o,

	// accepted load to the response queue
	output logic                             push_o,
	output logic [dmem_pkg::TAG_W-1:0]       push_tag_o,
	output logic [dmem_pkg::PTR_W-1:0]       push_ptr_o
);

	import dmem_pkg::*;

	localparam int IDX_W = (MSHR_NUM > 1) ? $clog2(MSHR_NUM) : 1;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(MSHR_NUM - 1);

	// entry state
	logic [MSHR_NUM-1:0] vld_r;
	logic [MSHR_NUM-1:0] rdy_r;

	// entry payload
	dmem_cmd_e              cmd_r  [MSHR_NUM];
	logic [LINE_ADDR_W-1:0] addr_r [MSHR_NUM];
	logic [WORD_W-1:0]      data_r [MSHR_NUM];
	logic [PTR_W-1:0]       ptr_r  [MSHR_NUM];

	logic [IDX_W-1:0] head_r;
	logic             head_wrap_r;
	logic [IDX_W-1:0] tail_r;
	logic             tail_wrap_r;

	logic                issue_en;
	logic [MSHR_NUM-1:0] wb_hit;

	// --------------------
	// head command
	// --------------------

	assign full_o   = (head_wrap_r != tail_wrap_r) && (head_r == tail_r);
	assign issue_en = vld_r[head_r] && rdy_r[head_r] && !rsp_stall_i;

	assign dmem_cmd_o    = issue_en ? cmd_r[head_r] : CMD_NONE;
	assign dmem_addr_o   = addr_r[head_r];
	assign dmem_data_o   = data_r[head_r];
	assign dmem_accept_o = issue_en && (dmem_resp_tag_i != TAG_NONE);

	// only loads expect data back
	assign push_o     = dmem_accept_o && (cmd_r[head_r] == CMD_LOAD);
	assign push_tag_o = dmem_resp_tag_i;
	assign push_ptr_o = ptr_r[head_r];

	// every waiting entry of the written-back line takes the data
	always_comb begin
		for (int i = 0; i < MSHR_NUM; i++) begin
			wb_hit[i] = bus_wb_vld_i && vld_r[i] && (addr_r[i] == bus_wb_addr_i);
		end
	end

	// --------------------
	// control state
	// --------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r       <= '0;
			rdy_r       <= '0;
			head_r      <= '0;
			head_wrap_r <= 1'b0;
			tail_r      <= '0;
			tail_wrap_r <= 1'b0;
		end else begin
			rdy_r <= rdy_r | wb_hit;
			if (dmem_accept_o) begin
				vld_r[head_r] <= 1'b0;
				rdy_r[head_r] <= 1'b0;
				if (head_r == LAST_IDX) begin
					head_r      <= '0;
					head_wrap_r <= !head_wrap_r;
				end else begin
					head_r <= head_r + 1'b1;
				end
			end
			// alloc after pop, a full queue reuses the freed head slot
			if (alloc_i) begin
				vld_r[tail_r] <= 1'b1;
				rdy_r[tail_r] <= (alloc_cmd_i == CMD_LOAD);
				if (tail_r == LAST_IDX) begin
					tail_r      <= '0;
					tail_wrap_r <= !tail_wrap_r;
				end else begin
					tail_r <= tail_r + 1'b1;
				end
			end
		end
	end

	// --------------------
	// payload
	// --------------------

	always_ff @(posedge clk) begin
		for (int i = 0; i < MSHR_NUM; i++) begin
			if (wb_hit[i]) begin
				data_r[i] <= bus_wb_data_i;
			end
		end
		if (alloc_i) begin
			cmd_r[tail_r]  <= alloc_cmd_i;
			addr_r[tail_r] <= alloc_addr_i;
			data_r[tail_r] <= '0;
			ptr_r[tail_r]  <= alloc_ptr_i;
		end
	end

endmodule

// File: logic/mshr_response.sv
// Memory response queue
// Circular queue of tag and bus pointer pairs for loads accepted
// by memory. Memory returns in accept order, so only the head tag
// is compared. A match returns the word to the bus with its
// pointer and pops the head at the next edge.

`timescale 1ns/1ps

module mshr_response #(
	parameter int MSHR_NUM = 4
) (
	input  logic                        clk,
	input  logic                        rst,

	// accepted load from the issue queue
	input  logic                        push_i,
	input  logic [dmem_pkg::TAG_W-1:0]  push_tag_i,
	input  logic [dmem_pkg::PTR_W-1:0]  push_ptr_i,

	// memory return
	input  logic [dmem_pkg::TAG_W-1:0]  dmem_ret_tag_i,
	input  logic [dmem_pkg::WORD_W-1:0] dmem_data_i,

	output logic                        rsp_stall_o,
	output logic                        bus_rsp_vld_o,
	output logic [dmem_pkg::PTR_W-1:0]  bus_rsp_ptr_o,
	output logic [dmem_pkg::WORD_W-1:0] bus_rsp_data_o
);

	import dmem_pkg::*;

	localparam int IDX_W = (MSHR_NUM > 1) ? $clog2(MSHR_NUM) : 1;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(MSHR_NUM - 1);

	logic [TAG_W-1:0] tag_r [MSHR_NUM];
	logic [PTR_W-1:0] ptr_r [MSHR_NUM];

	logic [IDX_W-1:0] head_r;
	logic             head_wrap_r;
	logic [IDX_W-1:0] tail_r;
	logic             tail_wrap_r;

	logic empty;
	logic full;
	logic ret_hit;

	assign empty = (head_wrap_r == tail_wrap_r) && (head_r == tail_r);
	assign full  = (head_wrap_r != tail_wrap_r) && (head_r == tail_r);

	// head tag match, ignore tag 0
	assign ret_hit = !empty && (dmem_ret_tag_i != TAG_NONE) &&
		(dmem_ret_tag_i == tag_r[head_r]);

	// a return this cycle frees a slot for the next push
	assign rsp_stall_o = full && !ret_hit;

	assign bus_rsp_vld_o  = ret_hit;
	assign bus_rsp_ptr_o  = ptr_r[head_r];
	assign bus_rsp_data_o = dmem_data_i;

	// --------------------
	// pointers
	// --------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r      <= '0;
			head_wrap_r <= 1'b0;
			tail_r      <= '0;
			tail_wrap_r <= 1'b0;
		end else begin
			if (ret_hit) begin
				if (head_r == LAST_IDX) begin
					head_r      <= '0;
					head_wrap_r <= !head_wrap_r;
				end else begin
					head_r <= head_r + 1'b1;
				end
			end
			if (push_i) begin
				if (tail_r == LAST_IDX) begin
					tail_r      <= '0;
					tail_wrap_r <= !tail_wrap_r;
				end else begin
					tail_r <= tail_r + 1'b1;
				end
			end
		end
	end

	// tag and pointer slots
	always_ff @(posedge clk) begin
		if (push_i) begin
			tag_r[tail_r] <= push_tag_i;
			ptr_r[tail_r] <= push_ptr_i;
		end
	end

endmodule

// File: sim/tb_dmem_ctrl.sv
// Testbench for the memory-side coherence controller
// Drives random bus requests and write-backs, models a tagged
// variable-latency data memory, and checks acks, memory commands
// and load responses against a reference model of the directory
// state and both queues.

`timescale 1ns/1ps

module tb_dmem_ctrl;

	import coh_pkg::*;
	import dmem_pkg::*;

	localparam int MSHR_NUM   = 4;
	localparam int RST_CYCLES = 16;
	localparam int N_RAND     = 1584;
	localparam int N_BP       = 400;
	// twice the traffic length leaves room for the final drain
	localparam int MAX_CYCLES = 2 * (RST_CYCLES + N_RAND + N_BP);

	// traffic modes
	localparam int M_RAND   = 0;
	localparam int M_REFUSE = 1;
	localparam int M_DRAIN  = 2;

	logic                   clk;
	logic                   rst;
	coh_msg_e               req_msg;
	logic [LINE_ADDR_W-1:0] req_addr;
	logic [PTR_W-1:0]       req_ptr;
	logic                   bus_req_ack;
	logic                   wb_vld;
	logic [LINE_ADDR_W-1:0] wb_addr;
	logic [WORD_W-1:0]      wb_data;
	logic                   bus_rsp_vld;
	logic [PTR_W-1:0]       bus_rsp_ptr;
	logic [WORD_W-1:0]      bus_rsp_data;
	dmem_cmd_e              dmem_cmd;
	logic [LINE_ADDR_W-1:0] dmem_addr;
	logic [WORD_W-1:0]      dmem_data;
	logic [TAG_W-1:0]       resp_tag;
	logic [TAG_W-1:0]       ret_tag;
	logic [WORD_W-1:0]      mem_data;

	integer seed = 29232;
	int     cycle = 0;

	// memory model
	logic [WORD_W-1:0] mem [NUM_LINES];
	logic [TAG_W-1:0]  next_tag;
	logic [TAG_W-1:0]  r_tag [$];
	logic [WORD_W-1:0] r_data [$];
	int                r_due [$];

	// reference model
	line_state_e            ref_st [NUM_LINES];
	logic [WORD_W-1:0]      ref_mem [NUM_LINES];
	dmem_cmd_e              q_cmd [$];
	logic [LINE_ADDR_W-1:0] q_addr [$];
	logic [PTR_W-1:0]       q_ptr [$];
	logic [WORD_W-1:0]      q_data [$];
	logic                   q_rdy [$];
	logic [PTR_W-1:0]       e_ptr [$];
	logic [WORD_W-1:0]      e_word [$];
	logic [LINE_ADDR_W-1:0] w_addr [$];

	int n_load;
	int n_rsp;
	int n_store;
	int n_refused;
	int n_getm_full;

	dmem_ctrl #(
		.MSHR_NUM (MSHR_NUM)
	) dmem_ctrl_i (
		.clk             (clk),
		.rst             (rst),
		.bus_req_msg_i   (req_msg),
		.bus_req_addr_i  (req_addr),
		.bus_req_ptr_i   (req_ptr),
		.bus_req_ack_o   (bus_req_ack),
		.bus_wb_vld_i    (wb_vld),
		.bus_wb_addr_i   (wb_addr),
		.bus_wb_data_i   (wb_data),
		.bus_rsp_vld_o   (bus_rsp_vld),
		.bus_rsp_ptr_o   (bus_rsp_ptr),
		.bus_rsp_data_o  (bus_rsp_data),
		.dmem_cmd_o      (dmem_cmd),
		.dmem_addr_o     (dmem_addr),
		.dmem_data_o     (dmem_data),
		.dmem_resp_tag_i (resp_tag),
		.dmem_ret_tag_i  (ret_tag),
		.dmem_data_i     (mem_data)
	);

	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

	// cycle count and hang guard
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$fatal(1, "run stopped by timeout");
		end
	end

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	function automatic logic [WORD_W-1:0] fill_word(input int a);
		return 64'hfeed_0000_0000_0000 | (64'(a) << 32) | (64'(a) * 64'h0101_0101);
	endfunction

	// --------------------
	// MSI decision table
	// --------------------

	function automatic logic table_ack(input line_state_e st, input coh_msg_e msg,
		input logic stall, output dmem_cmd_e cmd, output line_state_e nxt);
		cmd = CMD_NONE;
		nxt = st;
		case ({st, msg})
			{ST_I, GET_S}: begin
				cmd = CMD_LOAD;
				nxt = ST_S;
			end
			{ST_I, GET_M}: nxt = ST_M;
			{ST_S, GET_M}: nxt = ST_M;
			{ST_M, PUT_M}: begin
				cmd = CMD_STORE;
				nxt = ST_I;
			end
			{ST_M, GET_S}: begin
				cmd = CMD_STORE;
				nxt = ST_S;
			end
			default: return 1'b0;
		endcase
		// only requests that need an entry can stall
		return (cmd == CMD_NONE) || !stall;
	endfunction

	// --------------------
	// stimulus
	// --------------------

	task automatic drive_inputs(input int mode);
		int r;
		r = $random(seed);
		req_msg  = (mode == M_DRAIN) ? MSG_NONE : coh_msg_e'(r[1:0]);
		// 16 lines keep state transitions frequent
		req_addr = {2'b00, r[5:2]};
		req_ptr  = r[8:6];
		if (mode == M_REFUSE) begin
			resp_tag = TAG_NONE;
		end else if (mode == M_DRAIN || r[11:10] != 2'b00) begin
			resp_tag = next_tag;
		end else begin
			resp_tag = TAG_NONE;
		end
		if (w_addr.size() > 0 && (r[9] || mode == M_DRAIN)) begin
			wb_vld  = 1'b1;
			wb_addr = w_addr.pop_front();
			wb_data = {$random(seed), $random(seed)};
		end else begin
			wb_vld = 1'b0;
		end
		// in-order return once the delay has run out
		if (r_tag.size() > 0 && r_due[0] <= cycle) begin
			ret_tag  = r_tag[0];
			mem_data = r_data[0];
		end else begin
			ret_tag  = TAG_NONE;
			mem_data = '0;
		end
	endtask

	// --------------------
	// checks and model update
	// --------------------

	task automatic check_cycle(input int mode);
		logic        ret_now;
		logic        exp_issue;
		logic        exp_accept;
		logic        stall;
		logic        ack;
		dmem_cmd_e   acmd;
		line_state_e nxt;
		int          i;
		ret_now    = (ret_tag != TAG_NONE);
		exp_issue  = (q_cmd.size() > 0) && q_rdy[0] &&
			!((r_tag.size() == MSHR_NUM) && !ret_now);
		exp_accept = exp_issue && (resp_tag != TAG_NONE);
		stall      = (q_cmd.size() == MSHR_NUM) && !exp_accept;
		ack        = table_ack(ref_st[req_addr], req_msg, stall, acmd, nxt);

		check_eq(bus_req_ack, ack, "request ack");
		check_eq(dmem_cmd, exp_issue ? q_cmd[0] : CMD_NONE, "memory command");
		if (exp_issue) begin
			check_eq(dmem_addr, q_addr[0], "memory address");
			if (q_cmd[0] == CMD_STORE) begin
				check_eq(dmem_data, q_data[0], "store data");
			end
		end
		if (bus_rsp_vld === 1'b1) begin
			n_rsp++;
		end
		check_eq(bus_rsp_vld, ret_now, "response valid");
		if (ret_now) begin
			check_eq(bus_rsp_ptr, e_ptr.pop_front(), "response pointer");
			check_eq(bus_rsp_data, e_word.pop_front(), "response word");
			void'(r_tag.pop_front());
			void'(r_data.pop_front());
			void'(r_due.pop_front());
		end

		if (exp_accept) begin
			if (q_cmd[0] == CMD_STORE) begin
				mem[dmem_addr]      = dmem_data;
				ref_mem[q_addr[0]]  = q_data[0];
				n_store++;
			end else begin
				r_tag.push_back(resp_tag);
				r_data.push_back(mem[dmem_addr]);
				r_due.push_back(cycle + 1 + ($unsigned($random(seed)) % 6));
				e_ptr.push_back(q_ptr[0]);
				e_word.push_back(ref_mem[q_addr[0]]);
			end
			next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			void'(q_cmd.pop_front());
			void'(q_addr.pop_front());
			void'(q_ptr.pop_front());
			void'(q_data.pop_front());
			void'(q_rdy.pop_front());
		end

		// write-back fills every queued entry of that line
		if (wb_vld) begin
			for (i = 0; i < q_cmd.size(); i++) begin
				if (q_addr[i] == wb_addr) begin
					q_data[i] = wb_data;
					q_rdy[i]  = 1'b1;
				end
			end
		end

		if (mode == M_REFUSE && acmd != CMD_NONE && !ack) begin
			n_refused++;
		end
		if (mode == M_REFUSE && stall && req_msg == GET_M && ack) begin
			n_getm_full++;
		end

		if (ack) begin
			ref_st[req_addr] = nxt;
			if (acmd != CMD_NONE) begin
				q_cmd.push_back(acmd);
				q_addr.push_back(req_addr);
				q_ptr.push_back(req_ptr);
				q_data.push_back('0);
				q_rdy.push_back(acmd == CMD_LOAD);
				if (acmd == CMD_STORE) begin
					w_addr.push_back(req_addr);
				end else begin
					n_load++;
				end
			end
		end
	endtask

	task automatic run_cycle(input int mode);
		@(negedge clk);
		drive_inputs(mode);
		@(posedge clk);
		check_cycle(mode);
	endtask

	initial begin
		rst      = 1'b1;
		req_msg  = MSG_NONE;
		req_addr = '0;
		req_ptr  = '0;
		wb_vld   = 1'b0;
		wb_addr  = '0;
		wb_data  = '0;
		resp_tag = TAG_NONE;
		ret_tag  = TAG_NONE;
		mem_data = '0;
		next_tag = 4'd1;
		for (int a = 0; a < NUM_LINES; a++) begin
			mem[a]     = fill_word(a);
			ref_mem[a] = fill_word(a);
			ref_st[a]  = ST_I;
		end

		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(posedge clk);
		check_eq(dmem_cmd, CMD_NONE, "command after reset");
		check_eq(bus_req_ack, 1'b0, "ack after reset");
		check_eq(bus_rsp_vld, 1'b0, "response valid after reset");

		repeat (N_RAND) run_cycle(M_RAND);
		// memory refuses, queue fills up
		repeat (N_BP) run_cycle(M_REFUSE);
		while (q_cmd.size() > 0 || r_tag.size() > 0 || w_addr.size() > 0) begin
			run_cycle(M_DRAIN);
		end

		check_eq(n_rsp, n_load, "responses against loads");
		check_eq(n_store > 0, 1'b1, "stores reaching memory");
		check_eq(n_refused > 0, 1'b1, "allocating requests refused while full");
		check_eq(n_getm_full > 0, 1'b1, "GET_M acked while full");
		$display("All tests passed");
		$finish;
	end

endmodule
